// File: src/kbd_defines.svh
// keyboard input constants
`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

// equal samples needed before the filtered ps2 clock changes level
`define PS2_FILTER_LEN 4

// idle system cycles inside a frame before a partial frame is dropped
`define PS2_TIMEOUT_CYCLES 2000

// jump pulse length in clock cycles
`define JUMP_PULSE_CYCLES 51

`endif

// File: src/ps2_pkg.sv
// ps2 byte and keycode types
package ps2_pkg;

    // one byte from the keyboard, data bits only
    typedef logic [7:0] scan_byte_t;

    // prefix (00, F0, E0) in the upper byte and scan code in the lower byte
    typedef logic [15:0] keycode_t;

    localparam scan_byte_t BREAK_PREFIX = 8'hF0; // key released
    localparam scan_byte_t EXT_PREFIX   = 8'hE0; // extended key set

endpackage

// File: src/game_pkg.sv
// game control codes
package game_pkg;

    // set 2 scan codes of the control keys
    localparam logic [7:0] KEY_LEFT    = 8'h1C; // A
    localparam logic [7:0] KEY_RIGHT   = 8'h23; // D
    localparam logic [7:0] KEY_JUMP    = 8'h1D; // W
    localparam logic [7:0] KEY_RESTART = 8'h29; // space

    // down counter behind the jump pulse
    typedef logic [7:0] jump_ctr_t;

endpackage

// File: src/ps2_rx.sv
// ps2 frame receiver
`timescale 1ns/1ps
`include "kbd_defines.svh"

module ps2_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output ps2_pkg::scan_byte_t rx_byte,
    output logic                rx_valid,
    output logic                frame_error
);

    localparam int FLT_W = $clog2(`PS2_FILTER_LEN + 1);
    localparam int TMO_W = 12;

    logic [1:0]       clk_sync;
    logic [1:0]       data_sync;
    logic             clk_filt;
    logic [FLT_W-1:0] flt_cnt;
    logic             clk_fall;
    logic [10:0]      shreg;
    logic [3:0]       bit_cnt;
    logic [TMO_W-1:0] tmo_cnt;
    logic             frame_done;
    logic             frame_ok;

    // both lines idle high
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // level only moves after a run of equal samples
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_filt <= 1'b1;
            flt_cnt  <= '0;
        end else if (clk_sync[1] == clk_filt) begin
            flt_cnt <= '0;
        end else if (flt_cnt == FLT_W'(`PS2_FILTER_LEN - 1)) begin
            clk_filt <= clk_sync[1];
            flt_cnt  <= '0;
        end else begin
            flt_cnt <= flt_cnt + 1'b1;
        end
    end

    // high for the one cycle in which the filtered clock drops
    assign clk_fall = clk_filt & ~clk_sync[1] & (flt_cnt == FLT_W'(`PS2_FILTER_LEN - 1));

    // start 0, odd parity over data and parity bit, stop 1
    assign frame_ok = ~shreg[0] & (^shreg[9:1]) & shreg[10];

    // lsb first so new bits enter at the top
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shreg <= {data_sync[1], shreg[10:1]};
        end
        if (frame_done) begin
            rx_byte <= shreg[8:1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= '0;
            tmo_cnt     <= '0;
            frame_done  <= 1'b0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            frame_done  <= clk_fall && (bit_cnt == 4'd10);
            rx_valid    <= frame_done & frame_ok;
            frame_error <= frame_done & ~frame_ok;

            if (clk_fall) begin
                tmo_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0; // stop bit in
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != '0) begin
                // drop a frame that stalls mid-way
                if (tmo_cnt == TMO_W'(`PS2_TIMEOUT_CYCLES - 1)) begin
                    bit_cnt <= '0;
                    tmo_cnt <= '0;
                end else begin
                    tmo_cnt <= tmo_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/keycode_assembler.sv
// ps2 keycode assembler
`timescale 1ns/1ps

module keycode_assembler (
    input  logic                clk,
    input  logic                rst,
    input  ps2_pkg::scan_byte_t rx_byte,
    input  logic                rx_valid,
    output ps2_pkg::keycode_t   keycode,
    output logic                keycode_valid
);

    logic break_flag;
    logic ext_flag;

    always_ff @(posedge clk) begin
        if (rst) begin
            break_flag    <= 1'b0;
            ext_flag      <= 1'b0;
            keycode_valid <= 1'b0;
        end else begin
            keycode_valid <= 1'b0;
            if (rx_valid) begin
                if (rx_byte == ps2_pkg::BREAK_PREFIX) begin
                    break_flag <= 1'b1;
                end else if (rx_byte == ps2_pkg::EXT_PREFIX) begin
                    ext_flag <= 1'b1;
                end else begin
                    // code byte ends the event
                    break_flag    <= 1'b0;
                    ext_flag      <= 1'b0;
                    keycode_valid <= ~(break_flag & ext_flag); // no extended breaks
                end
            end
        end
    end

    // prefix picked from the flags seen before the code byte
    always_ff @(posedge clk) begin
        if (rx_valid && rx_byte != ps2_pkg::BREAK_PREFIX && rx_byte != ps2_pkg::EXT_PREFIX) begin
            if (ext_flag) begin
                keycode <= {ps2_pkg::EXT_PREFIX, rx_byte};
            end else if (break_flag) begin
                keycode <= {ps2_pkg::BREAK_PREFIX, rx_byte};
            end else begin
                keycode <= {8'h00, rx_byte};
            end
        end
    end

endmodule

// File: src/key_decoder_movement.sv
// movement key decoder
`timescale 1ns/1ps
`include "kbd_defines.svh"

module key_decoder_movement (
    input  logic              clk,
    input  logic              rst,
    input  ps2_pkg::keycode_t keycode,
    input  logic              keycode_valid,
    output logic              right,
    output logic              left,
    output logic              jump,
    output logic              restart_button
);

    logic [7:0]         prefix;
    logic [7:0]         code;
    logic               make_ev;
    logic               break_ev;
    game_pkg::jump_ctr_t jump_ctr;

    assign prefix = keycode[15:8];
    assign code   = keycode[7:0];

    // extended events match neither
    assign make_ev  = keycode_valid && (prefix == 8'h00);
    assign break_ev = keycode_valid && (prefix == ps2_pkg::BREAK_PREFIX);

    // held levels with left and right independent of each other
    always_ff @(posedge clk) begin
        if (rst) begin
            right          <= 1'b0;
            left           <= 1'b0;
            restart_button <= 1'b0;
        end else if (make_ev || break_ev) begin
            if (code == game_pkg::KEY_LEFT) begin
                left <= make_ev;
            end
            if (code == game_pkg::KEY_RIGHT) begin
                right <= make_ev;
            end
            if (code == game_pkg::KEY_RESTART) begin
                restart_button <= make_ev; // held while space is down
            end
        end
    end

    // a new make reloads and a release is ignored
    always_ff @(posedge clk) begin
        if (rst) begin
            jump_ctr <= '0;
        end else if (make_ev && code == game_pkg::KEY_JUMP) begin
            jump_ctr <= game_pkg::jump_ctr_t'(`JUMP_PULSE_CYCLES);
        end else if (jump_ctr != '0) begin
            jump_ctr <= jump_ctr - 1'b1;
        end
    end

    assign jump = (jump_ctr != '0);

endmodule

// File: src/player_input_top.sv
// player keyboard input top
`timescale 1ns/1ps

module player_input_top (
    input  logic clk,
    input  logic rst,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic right,
    output logic left,
    output logic jump,
    output logic restart_button,
    output logic frame_error
);

    ps2_pkg::scan_byte_t rx_byte;
    logic                rx_valid;
    ps2_pkg::keycode_t   keycode;
    logic                keycode_valid;

    ps2_rx u_ps2_rx (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    keycode_assembler u_keycode_assembler (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .keycode       (keycode),
        .keycode_valid (keycode_valid)
    );

    key_decoder_movement u_key_decoder_movement (
        .clk            (clk),
        .rst            (rst),
        .keycode        (keycode),
        .keycode_valid  (keycode_valid),
        .right          (right),
        .left           (left),
        .jump           (jump),
        .restart_button (restart_button)
    );

endmodule

// File: tb/tb_player_input.sv
// player input testbench
`timescale 1ns/1ps
`include "kbd_defines.svh"

module tb_player_input;

    localparam int HALF_BIT  = 20;  // system cycles per ps2 half bit
    localparam int SETTLE    = 40;
    localparam int MAX_TESTS = 64;

    logic clk;
    logic rst;
    logic ps2_clk;
    logic ps2_data;
    logic right;
    logic left;
    logic jump;
    logic restart_button;
    logic frame_error;

    // test table filled from the data file
    string      t_name    [0:MAX_TESTS-1];
    int         t_nbytes  [0:MAX_TESTS-1];
    logic [7:0] t_bytes   [0:MAX_TESTS-1][0:2];
    bit         t_corrupt [0:MAX_TESTS-1];
    logic [3:0] t_exp     [0:MAX_TESTS-1]; // right, left, restart, jump seen
    int         n_tests;
    bit         loaded;

    // monitor state
    logic jump_q;
    int   jump_run;
    int   jump_width;
    int   jump_rises;
    int   jump_falls;
    int   ferr_pulses;

    int err_total;
    int failed_tests;

    player_input_top dut (
        .clk            (clk),
        .rst            (rst),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .right          (right),
        .left           (left),
        .jump           (jump),
        .restart_button (restart_button),
        .frame_error    (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // jump and frame_error as seen at each rising edge
    always @(posedge clk) begin
        if (rst) begin
            jump_q      <= 1'b0;
            jump_run    <= 0;
            jump_width  <= 0;
            jump_rises  <= 0;
            jump_falls  <= 0;
            ferr_pulses <= 0;
        end else begin
            jump_q <= jump;
            if (jump && !jump_q) begin
                jump_rises <= jump_rises + 1;
            end
            if (jump) begin
                jump_run <= jump_run + 1;
            end else if (jump_q) begin
                jump_width <= jump_run; // high samples of the pulse just ended
                jump_falls <= jump_falls + 1;
                jump_run   <= 0;
            end
            if (frame_error) begin
                ferr_pulses <= ferr_pulses + 1;
            end
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // keyboard side of one frame with data moving while ps2_clk is high
    task automatic send_frame(input logic [7:0] data, input bit bad_parity);
        logic [10:0] frame;
        logic        par;
        par = ~^data; // odd parity
        if (bad_parity) begin
            par = ~par;
        end
        frame = {1'b1, par, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic check_level(input string test, input string what, input logic got,
                               input logic exp, inout int errs);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s %s is %b, expected %b", $time, test, what, got, exp);
            errs++;
        end
    endtask

    // each line has name, byte count, three hex bytes, bad parity and four expected levels
    task automatic load_tests();
        int                fd;
        int                code;
        int                nb;
        int                cor;
        int                er;
        int                el;
        int                ers;
        int                ejs;
        string             nm;
        logic [7:0]        b0;
        logic [7:0]        b1;
        logic [7:0]        b2;
        logic [8*160-1:0]  line;
        n_tests = 0;
        fd = $fopen("tb/player_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file tb/player_testdata.txt");
            err_total++;
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = '0;
            code = $fgets(line, fd);
            code = $sscanf(line, "%s %d %h %h %h %d %d %d %d %d",
                           nm, nb, b0, b1, b2, cor, er, el, ers, ejs);
            if (code == 10) begin // comments and blank lines fall short
                t_name[n_tests]     = nm;
                t_nbytes[n_tests]   = nb;
                t_bytes[n_tests][0] = b0;
                t_bytes[n_tests][1] = b1;
                t_bytes[n_tests][2] = b2;
                t_corrupt[n_tests]  = (cor != 0);
                t_exp[n_tests]      = {er != 0, el != 0, ers != 0, ejs != 0};
                n_tests++;
            end
        end
        $fclose(fd);
        if (n_tests == 0) begin
            $display("no test lines found in tb/player_testdata.txt");
            err_total++;
        end
    endtask

    task automatic check_reset_state();
        int errs;
        errs = 0;
        check_level("reset_state", "right", right, 1'b0, errs);
        check_level("reset_state", "left", left, 1'b0, errs);
        check_level("reset_state", "jump", jump, 1'b0, errs);
        check_level("reset_state", "restart_button", restart_button, 1'b0, errs);
        check_level("reset_state", "frame_error", frame_error, 1'b0, errs);
        $display("test reset_state: %s", (errs == 0) ? "ok" : "FAIL");
        err_total += errs;
        if (errs != 0) begin
            failed_tests++;
        end
    endtask

    task automatic run_test(input int t);
        int errs;
        int rises0;
        int falls0;
        int ferr0;
        int waited;
        bit jump_seen;
        bit ferr_seen;
        errs   = 0;
        rises0 = jump_rises;
        falls0 = jump_falls;
        ferr0  = ferr_pulses;
        for (int b = 0; b < t_nbytes[t]; b++) begin
            wait_cycles($urandom % 51); // idle gap between frames
            send_frame(t_bytes[t][b], t_corrupt[t]);
        end
        wait_cycles(SETTLE);
        jump_seen = (jump_rises != rises0);
        ferr_seen = (ferr_pulses != ferr0);
        check_level(t_name[t], "right", right, t_exp[t][3], errs);
        check_level(t_name[t], "left", left, t_exp[t][2], errs);
        check_level(t_name[t], "restart_button", restart_button, t_exp[t][1], errs);
        check_level(t_name[t], "jump seen", jump_seen, t_exp[t][0], errs);
        check_level(t_name[t], "frame_error seen", ferr_seen, t_corrupt[t], errs);

        // pulse may still be running here
        if (t_exp[t][0] && jump_seen) begin
            waited = 0;
            while (jump_falls == falls0 && waited < 2 * `JUMP_PULSE_CYCLES) begin
                wait_cycles(1);
                waited++;
            end
            if (jump_falls == falls0) begin
                $display("test %s: jump stayed high and never ended", t_name[t]);
                errs++;
            end else begin
                assert (jump_width == `JUMP_PULSE_CYCLES) else begin
                    $display("MISMATCH at %0t: %s jump lasted %0d cycles, expected %0d",
                             $time, t_name[t], jump_width, `JUMP_PULSE_CYCLES);
                    errs++;
                end
            end
        end

        $display("test %s: %s", t_name[t], (errs == 0) ? "ok" : "FAIL");
        err_total += errs;
        if (errs != 0) begin
            failed_tests++;
        end
    endtask

    initial begin
        void'($urandom(17214));
        err_total    = 0;
        failed_tests = 0;
        loaded       = 1'b0;
        rst          = 1'b1;
        ps2_clk      = 1'b1; // bus idle
        ps2_data     = 1'b1;
        load_tests();
        loaded = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, errors %0d", n_tests + 1, failed_tests, err_total);
        if (err_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // three frames of 11 bits per line with twice the margin
    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(n_tests + 1) * 3 * 11 * 40 * 100 * 2;
        #(limit_ns);
        $display("watchdog: the run did not finish within %0d ns", limit_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/ps2_pkg.sv
src/game_pkg.sv
src/ps2_rx.sv
src/keycode_assembler.sv
src/key_decoder_movement.sv
src/player_input_top.sv
tb/tb_player_input.sv

// File: Bender.yml
package:
  name: player_input

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ps2_pkg.sv
      - src/game_pkg.sv
      - src/ps2_rx.sv
      - src/keycode_assembler.sv
      - src/key_decoder_movement.sv
      - src/player_input_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_player_input.sv

// File: tb/player_testdata.txt
# name nbytes byte0 byte1 byte2 bad_parity right left restart jump_seen
# bytes in hex with unused byte columns at 00, all other columns decimal
# held movement
left_make         1 1C 00 00 0 0 1 0 0
right_make        1 23 00 00 0 1 1 0 0
left_break        2 F0 1C 00 0 1 0 0 0
right_break       2 F0 23 00 0 0 0 0 0
# jump pulse
jump_make         1 1D 00 00 0 0 0 0 1
jump_break        2 F0 1D 00 0 0 0 0 0
jump_again        1 1D 00 00 0 0 0 0 1
right_hold        1 23 00 00 0 1 0 0 0
jump_with_right   1 1D 00 00 0 1 0 0 1
right_release     2 F0 23 00 0 0 0 0 0
# restart key
restart_make      1 29 00 00 0 0 0 1 0
restart_break     2 F0 29 00 0 0 0 0 0
restart_hold      1 29 00 00 0 0 0 1 0
left_with_restart 1 1C 00 00 0 0 1 1 0
restart_release   2 F0 29 00 0 0 1 0 0
left_release      2 F0 1C 00 0 0 0 0 0
# extended codes
ext_left          2 E0 1C 00 0 0 0 0 0
ext_right         2 E0 23 00 0 0 0 0 0
ext_jump          2 E0 1D 00 0 0 0 0 0
left_hold         1 1C 00 00 0 0 1 0 0
ext_break_left    3 E0 F0 1C 0 0 1 0 0
# keys outside the control set
other_make        1 1B 00 00 0 0 1 0 0
other_break       2 F0 1B 00 0 0 1 0 0
# bad frames
bad_right         1 23 00 00 1 0 1 0 0
good_right        1 23 00 00 0 1 1 0 0
bad_jump          1 1D 00 00 1 1 1 0 0
bad_prefix        1 F0 00 00 1 1 1 0 0
make_after_bad    1 1C 00 00 0 1 1 0 0
good_jump         1 1D 00 00 0 1 1 0 1
release_right     2 F0 23 00 0 0 1 0 0
release_left      2 F0 1C 00 0 0 0 0 0
